/* view_pkg.sv */
/* screen geometry, object counts, colour codes and the job types of the display controller
   object kinds are fixed by table index: gold first, then stone, then diamond */
package view_pkg;

	typedef logic [7:0]  coord_x_t;
	typedef logic [6:0]  coord_y_t;
	typedef logic [2:0]  color_t;
	typedef logic [3:0]  obj_idx_t;
	typedef logic [15:0] lfsr_t;

	localparam int SCR_W = 64;
	localparam int SCR_H = 48;

	localparam int MAX_GOLD    = 4;
	localparam int MAX_STONE   = 3;
	localparam int MAX_DIAMOND = 2;
	localparam int NUM_OBJ     = MAX_GOLD + MAX_STONE + MAX_DIAMOND;

	localparam int GOLD_SIZE    = 4;
	localparam int STONE_SIZE   = 6;
	localparam int DIAMOND_SIZE = 3;
	localparam int HOOK_W       = 2;
	localparam int HOOK_H       = 8;

	localparam int FRAME_CYCLES = 8192; // clocks per redraw in GAME
	localparam int FRAME_W      = $clog2(FRAME_CYCLES);
	typedef logic [FRAME_W-1:0] frame_cnt_t;

	localparam lfsr_t LFSR_SEED = 16'hace1;

	localparam color_t COL_START   = 3'd1;
	localparam color_t COL_BG      = 3'd2;
	localparam color_t COL_GOLD    = 3'd3;
	localparam color_t COL_STONE   = 3'd4;
	localparam color_t COL_DIAMOND = 3'd5;
	localparam color_t COL_HOOK    = 3'd6;
	localparam color_t COL_OVER    = 3'd7;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} obj_t; // top-left corner

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		coord_x_t w;
		coord_y_t h;
		color_t   color;
	} draw_job_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pix_t;

	typedef enum logic [3:0] {
		IDLE_START, DRAW_START, WAIT_GO, PLACE, DRAW_BG,
		DRAW_OBJ, DRAW_HOOK, GAME, DRAW_OVER, GAME_DONE
	} view_state_t;

	// square side of the object at a table index
	function automatic coord_x_t obj_size(obj_idx_t idx);
		if (idx < MAX_GOLD)
			return coord_x_t'(GOLD_SIZE);
		else if (idx < MAX_GOLD + MAX_STONE)
			return coord_x_t'(STONE_SIZE);
		else
			return coord_x_t'(DIAMOND_SIZE);
	endfunction

	function automatic color_t obj_color(obj_idx_t idx);
		if (idx < MAX_GOLD)
			return COL_GOLD;
		else if (idx < MAX_GOLD + MAX_STONE)
			return COL_STONE;
		else
			return COL_DIAMOND;
	endfunction

endpackage

/* object_placer.sv */
/* fills the object table on each place_req, one entry per cycle, ack after NUM_OBJ+1 cycles
   each object uses the shift register value after its own step; register is not reseeded */
`timescale 1ns/10ps

module object_placer (
	input  logic                clk,
	input  logic                resetn,
	input  logic                place_req,
	output logic                place_ack,
	input  view_pkg::obj_idx_t  obj_sel,
	output view_pkg::obj_t      obj
);

	view_pkg::lfsr_t    lfsr;
	view_pkg::lfsr_t    lfsr_nxt;
	view_pkg::obj_idx_t idx;
	view_pkg::coord_x_t size;
	view_pkg::obj_t     new_obj;
	view_pkg::obj_t     tbl [view_pkg::NUM_OBJ];

	logic [15:0] x_span;
	logic [15:0] y_span;
	logic [15:0] x_pos;
	logic [15:0] y_pos;
	logic        feedback;

	// taps 16 14 13 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign lfsr_nxt = {lfsr[14:0], feedback};

	assign size   = view_pkg::obj_size(idx);
	assign x_span = 16'(view_pkg::SCR_W) - 16'(size);
	assign y_span = 16'(view_pkg::SCR_H - view_pkg::HOOK_H) - 16'(size);

	// keep objects below the hook band
	assign x_pos = lfsr_nxt % x_span;
	assign y_pos = ({8'd0, lfsr_nxt[15:8]} % y_span) + 16'(view_pkg::HOOK_H);

	assign new_obj.x = view_pkg::coord_x_t'(x_pos);
	assign new_obj.y = view_pkg::coord_y_t'(y_pos);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lfsr      <= view_pkg::LFSR_SEED;
			idx       <= '0;
			place_ack <= 1'b0;
		end else begin
			if (place_req && !place_ack) begin
				if (idx == view_pkg::obj_idx_t'(view_pkg::NUM_OBJ)) begin
					place_ack <= 1'b1; // table complete
					idx       <= '0;
				end else begin
					tbl[idx] <= new_obj;
					lfsr     <= lfsr_nxt;
					idx      <= idx + 1'b1;
				end
			end else if (!place_req) begin
				place_ack <= 1'b0;
			end
		end
	end

	// combinational read port
	always_comb begin
		obj = '0;
		if (obj_sel < view_pkg::obj_idx_t'(view_pkg::NUM_OBJ))
			obj = tbl[obj_sel];
	end

	// four-phase handshake with the sequencer
	assert property (@(posedge clk) disable iff (!resetn)
		$rose(place_ack) |-> place_req)
		else $error("place_ack rose without place_req");

endmodule

/* view_sequencer.sv */
/* walks the screen sequence and issues one rectangle job at a time to the drawer
   hook_x is clamped so the hook stays on screen; objects are drawn in table order */
`timescale 1ns/10ps

module view_sequencer (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  go,
	input  logic                  game_end,
	input  view_pkg::coord_x_t    hook_x,
	output logic                  place_req,
	input  logic                  place_ack,
	output view_pkg::obj_idx_t    obj_sel,
	input  view_pkg::obj_t        obj,
	output view_pkg::draw_job_t   job,
	output logic                  job_req,
	input  logic                  job_ack
);

	localparam view_pkg::coord_x_t HOOK_X_MAX =
		view_pkg::coord_x_t'(view_pkg::SCR_W - view_pkg::HOOK_W);

	view_pkg::view_state_t state;
	view_pkg::obj_idx_t    obj_idx;
	view_pkg::frame_cnt_t  frame_cnt;
	view_pkg::draw_job_t   next_job;
	view_pkg::coord_x_t    hook_xc;

	logic drawing;
	logic job_done;
	logic frame_tick;

	assign obj_sel  = obj_idx;
	assign job_done = job_req && job_ack;
	assign hook_xc  = (hook_x > HOOK_X_MAX) ? HOOK_X_MAX : hook_x;

	assign drawing = (state == view_pkg::DRAW_START) || (state == view_pkg::DRAW_BG) ||
		(state == view_pkg::DRAW_OBJ) || (state == view_pkg::DRAW_HOOK) ||
		(state == view_pkg::DRAW_OVER);

	assign frame_tick = (frame_cnt == view_pkg::frame_cnt_t'(view_pkg::FRAME_CYCLES - 1));

	// job for the current state, full screen unless overridden
	always_comb begin
		next_job.x     = '0;
		next_job.y     = '0;
		next_job.w     = view_pkg::coord_x_t'(view_pkg::SCR_W);
		next_job.h     = view_pkg::coord_y_t'(view_pkg::SCR_H);
		next_job.color = view_pkg::COL_BG;
		case (state)
			view_pkg::DRAW_START: next_job.color = view_pkg::COL_START;
			view_pkg::DRAW_OVER:  next_job.color = view_pkg::COL_OVER;
			view_pkg::DRAW_OBJ: begin
				next_job.x     = obj.x;
				next_job.y     = obj.y;
				next_job.w     = view_pkg::obj_size(obj_idx);
				next_job.h     = view_pkg::coord_y_t'(view_pkg::obj_size(obj_idx));
				next_job.color = view_pkg::obj_color(obj_idx);
			end
			view_pkg::DRAW_HOOK: begin
				next_job.x     = hook_xc;
				next_job.w     = view_pkg::coord_x_t'(view_pkg::HOOK_W);
				next_job.h     = view_pkg::coord_y_t'(view_pkg::HOOK_H);
				next_job.color = view_pkg::COL_HOOK;
			end
			default: ;
		endcase
	end

	// job payload, loaded when a request goes out
	always_ff @(posedge clk) begin
		if (drawing && !job_req && !job_ack)
			job <= next_job;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= view_pkg::IDLE_START;
			obj_idx   <= '0;
			frame_cnt <= '0;
			job_req   <= 1'b0;
			place_req <= 1'b0;
		end else begin
			// wait for the previous ack to clear before the next request
			if (drawing && !job_req && !job_ack)
				job_req <= 1'b1;
			else if (job_done)
				job_req <= 1'b0;

			if (state == view_pkg::GAME)
				frame_cnt <= frame_cnt + 1'b1;
			else
				frame_cnt <= '0; // restarts on entry

			case (state)
				view_pkg::IDLE_START: state <= view_pkg::DRAW_START;
				view_pkg::DRAW_START: begin
					if (job_done)
						state <= view_pkg::WAIT_GO;
				end
				view_pkg::WAIT_GO, view_pkg::GAME_DONE: begin
					if (go) begin
						state     <= view_pkg::PLACE;
						place_req <= 1'b1;
					end
				end
				view_pkg::PLACE: begin
					if (place_req && place_ack)
						place_req <= 1'b0;
					else if (!place_req && !place_ack)
						state <= view_pkg::DRAW_BG;
				end
				view_pkg::DRAW_BG: begin
					if (job_done) begin
						obj_idx <= '0;
						state   <= view_pkg::DRAW_OBJ;
					end
				end
				view_pkg::DRAW_OBJ: begin
					if (job_done) begin
						if (obj_idx == view_pkg::obj_idx_t'(view_pkg::NUM_OBJ - 1))
							state <= view_pkg::DRAW_HOOK;
						else
							obj_idx <= obj_idx + 1'b1;
					end
				end
				view_pkg::DRAW_HOOK: begin
					if (job_done)
						state <= view_pkg::GAME;
				end
				view_pkg::GAME: begin
					if (game_end)
						state <= view_pkg::DRAW_OVER;
					else if (frame_tick)
						state <= view_pkg::DRAW_BG; // redraw, same objects
				end
				view_pkg::DRAW_OVER: begin
					if (job_done)
						state <= view_pkg::GAME_DONE;
				end
				default: state <= view_pkg::IDLE_START;
			endcase
		end
	end

	// drawer does not clip, placed objects and hook must fit
	assert property (@(posedge clk) disable iff (!resetn)
		job_req |-> (int'(job.x) + int'(job.w) <= view_pkg::SCR_W) &&
			(int'(job.y) + int'(job.h) <= view_pkg::SCR_H))
		else $error("job reaches outside the screen");

endmodule

/* rect_drawer.sv */
/* emits w*h pixels of one job in row-major order, one per clock, with no back-pressure
   jobs of zero width or height are not supported */
`timescale 1ns/10ps

module rect_drawer (
	input  logic                 clk,
	input  logic                 resetn,
	input  view_pkg::draw_job_t  job,
	input  logic                 job_req,
	output logic                 job_ack,
	output view_pkg::pix_t       pix,
	output logic                 pix_valid
);

	view_pkg::draw_job_t cur;
	view_pkg::coord_x_t  cx;
	view_pkg::coord_y_t  cy;

	logic busy;
	logic fin;  // last pixel went out
	logic last;

	assign last = (cx == cur.w - 1'b1) && (cy == cur.h - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			fin       <= 1'b0;
			job_ack   <= 1'b0;
			pix_valid <= 1'b0;
			cx        <= '0;
			cy        <= '0;
		end else begin
			pix_valid <= busy;
			fin       <= busy && last;

			if (busy) begin
				pix.x     <= cur.x + cx;
				pix.y     <= cur.y + cy;
				pix.color <= cur.color;
				if (last) begin
					busy <= 1'b0;
				end else if (cx == cur.w - 1'b1) begin
					cx <= '0;
					cy <= cy + 1'b1;
				end else begin
					cx <= cx + 1'b1;
				end
			end else if (job_req && !job_ack && !fin) begin
				cur  <= job;
				cx   <= '0;
				cy   <= '0;
				busy <= 1'b1;
			end

			if (fin)
				job_ack <= 1'b1;
			else if (!job_req)
				job_ack <= 1'b0;
		end
	end

	// jobs from the sequencer must fit on screen
	assert property (@(posedge clk) disable iff (!resetn)
		pix_valid |-> (pix.x < view_pkg::SCR_W) && (pix.y < view_pkg::SCR_H))
		else $error("pixel outside the screen");

endmodule

/* game_view.sv */
/* display controller top: object placer, view sequencer and rectangle drawer
   the pixel port has no back-pressure */
`timescale 1ns/10ps

module game_view (
	input  logic                clk,
	input  logic                resetn,
	input  logic                go,
	input  logic                game_end,
	input  view_pkg::coord_x_t  hook_x,
	output view_pkg::pix_t      pix,
	output logic                pix_valid
);

	logic                place_req;
	logic                place_ack;
	view_pkg::obj_idx_t  obj_sel;
	view_pkg::obj_t      obj;
	view_pkg::draw_job_t job;
	logic                job_req;
	logic                job_ack;

	object_placer i_placer (
		.clk       (clk),
		.resetn    (resetn),
		.place_req (place_req),
		.place_ack (place_ack),
		.obj_sel   (obj_sel),
		.obj       (obj)
	);

	view_sequencer i_seq (
		.clk       (clk),
		.resetn    (resetn),
		.go        (go),
		.game_end  (game_end),
		.hook_x    (hook_x),
		.place_req (place_req),
		.place_ack (place_ack),
		.obj_sel   (obj_sel),
		.obj       (obj),
		.job       (job),
		.job_req   (job_req),
		.job_ack   (job_ack)
	);

	rect_drawer i_drawer (
		.clk       (clk),
		.resetn    (resetn),
		.job       (job),
		.job_req   (job_req),
		.job_ack   (job_ack),
		.pix       (pix),
		.pix_valid (pix_valid)
	);

endmodule

/* tb_game_view.sv */
/* trace driven testbench, reads game_view_trace.txt from the directory the run starts in
   a screen is complete once its expected pixel count arrived, extra pixels show in an idle window */
`timescale 1ns/10ps

module tb_game_view;

	localparam int TIMEOUT = 20000; // frame tick plus a full redraw
	localparam int QUIET   = 200;   // idle cycles after each screen

	logic                clk;
	logic                resetn;
	logic                go;
	logic                game_end;
	view_pkg::coord_x_t  hook_x;
	view_pkg::pix_t      pix;
	logic                pix_valid;

	// running statistics, only written by the pixel monitor
	int n_pix = 0;
	int col_sum = 0;
	int xy_xor = 0;
	int n_off = 0;
	int pos_sum [8] = '{default: 0}; // per colour, sum of 64*y+x

	// snapshot at the start of a screen
	int base_pix;
	int base_col;
	int base_xor;
	int base_off;
	int base_pos [8];

	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	bit timed_out = 1'b0;
	bit bad_trace = 1'b0;

	game_view i_dut (
		.clk       (clk),
		.resetn    (resetn),
		.go        (go),
		.game_end  (game_end),
		.hook_x    (hook_x),
		.pix       (pix),
		.pix_valid (pix_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// sample mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (resetn && pix_valid) begin
			n_pix   += 1;
			col_sum += int'(pix.color);
			xy_xor  ^= int'(pix.x) ^ int'(pix.y);
			pos_sum[pix.color] += 64 * int'(pix.y) + int'(pix.x);
			if (int'(pix.x) >= view_pkg::SCR_W || int'(pix.y) >= view_pkg::SCR_H)
				n_off += 1;
		end
	end

	task automatic check_val(input string what, input int got, input int exp);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors += 1;
		end
	endtask

	task automatic take_base();
		base_pix = n_pix;
		base_col = col_sum;
		base_xor = xy_xor;
		base_off = n_off;
		for (int c = 0; c < 8; c++)
			base_pos[c] = pos_sum[c];
	endtask

	task automatic wait_pixels(input int count);
		int cyc;
		cyc = 0;
		while (n_pix - base_pix < count && cyc < TIMEOUT) begin
			@(posedge clk);
			cyc += 1;
		end
		if (n_pix - base_pix < count) begin
			$display("timeout: only %0d of %0d pixels arrived within %0d cycles",
				n_pix - base_pix, count, TIMEOUT);
			timed_out = 1'b1;
		end else begin
			repeat (QUIET) @(posedge clk); // idle in WAIT_GO, GAME or GAME_DONE
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          hx;
		int          err_before;
		int          exp_cnt, exp_col, exp_xor;
		int          exp_gold, exp_stone, exp_dia, exp_hook;
		string       line;
		logic [63:0] cmd;

		resetn   = 1'b0;
		go       = 1'b0;
		game_end = 1'b0;
		hook_x   = '0;
		repeat (16) @(posedge clk);
		#2;
		resetn = 1'b1;

		fd = $fopen("game_view_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file game_view_trace.txt");
			bad_trace = 1'b1;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				n = $fgets(line, fd);
				if (n == 0 || line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %d", cmd, hx, exp_cnt, exp_col,
					exp_xor, exp_gold, exp_stone, exp_dia, exp_hook);
				if (n != 9) begin
					$display("malformed trace line: %s", line);
					bad_trace = 1'b1;
					continue;
				end
				err_before = errors;
				tests_run += 1;

				@(posedge clk);
				#2;
				take_base();
				hook_x = view_pkg::coord_x_t'(hx);
				if (cmd == 64'("go"))
					go = 1'b1;
				else if (cmd == 64'("end"))
					game_end = 1'b1;
				else if (cmd != 64'("start") && cmd != 64'("frame")) begin
					$display("unknown trace command %0s", cmd);
					bad_trace = 1'b1;
				end
				@(posedge clk);
				#2;
				go       = 1'b0;
				game_end = 1'b0;

				wait_pixels(exp_cnt);
				if (!timed_out) begin
					check_val("pixel count", n_pix - base_pix, exp_cnt);
					check_val("colour sum", col_sum - base_col, exp_col);
					check_val("x^y xor", xy_xor ^ base_xor, exp_xor);
					check_val("gold position sum", pos_sum[3] - base_pos[3], exp_gold);
					check_val("stone position sum", pos_sum[4] - base_pos[4], exp_stone);
					check_val("diamond position sum", pos_sum[5] - base_pos[5], exp_dia);
					check_val("hook position sum", pos_sum[6] - base_pos[6], exp_hook);
					check_val("pixels off screen", n_off - base_off, 0);
				end
				if (errors != err_before || timed_out)
					tests_bad += 1;
				$display("test %0d (%0s, hook_x %0d): %s", tests_run, cmd, hx,
					(errors == err_before && !timed_out) ? "ok" : "FAILED");
			end
			$fclose(fd);
		end

		if (tests_run == 0)
			$display("no test was run from the trace");
		$display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_bad, errors);
		if (errors == 0 && tests_bad == 0 && tests_run > 0 && !bad_trace && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* game_view.f */
view_pkg.sv
object_placer.sv
view_sequencer.sv
rect_drawer.sv
game_view.sv
tb_game_view.sv

/* run.sh */
#!/bin/sh
# build and run the game_view testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_game_view \
	-f game_view.f -Mdir obj_dir

status=0
out=$(./obj_dir/Vtb_game_view) || status=$?
printf '%s\n' "$out"
[ "$status" -eq 0 ] || exit "$status"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'STATUS: PASS'

/* game_view_trace.txt */
# columns: command hook_x pixel_count colour_sum xy_xor gold_pos stone_pos diamond_pos hook_pos
# *_pos is the sum of 64*y+x over the pixels of that colour, xy_xor is the xor of x^y over all
# start screen after reset
start 0 3072 3072 0 0 0 0 0
# first round, objects placed from the reset seed
go 10 3278 6954 58 153616 195498 18225 3752
# frame tick, same objects, hook moved
frame 40 3278 6954 58 153616 195498 18225 4232
# game over screen
end 40 3072 21504 0 0 0 0 0
# second round, shift register continues from the first round
go 20 3278 6954 14 138688 185526 39213 3912
frame 5 3278 6954 14 138688 185526 39213 3672
end 5 3072 21504 0 0 0 0 0
